// File: common/mipsPkg.sv
//######################################
// MIPS pipeline shared definitions
//######################################

package mipsPkg;

    // word, instruction and PC width
    localparam int dataW    = 32;
    localparam int regAddrW = 5;

    // memory sizes in words
    localparam int imemDepth = 256;
    localparam int imemAddrW = 8;
    localparam int dmemDepth = 256;

    // opcodes
    localparam logic [5:0] opRType = 6'd0;
    localparam logic [5:0] opJ     = 6'd2;
    localparam logic [5:0] opBeq   = 6'd4;
    localparam logic [5:0] opAddiu = 6'd9;
    localparam logic [5:0] opLw    = 6'd35;
    localparam logic [5:0] opSw    = 6'd43;
    localparam logic [5:0] opFin   = 6'd63;

    // R-type funct field
    localparam logic [5:0] fnAddu = 6'd33;
    localparam logic [5:0] fnSubu = 6'd35;
    localparam logic [5:0] fnAnd  = 6'd36;
    localparam logic [5:0] fnOr   = 6'd37;
    localparam logic [5:0] fnSlt  = 6'd42;

    // ALU operations picked in decode
    localparam logic [2:0] aluAdd = 3'd0;
    localparam logic [2:0] aluSub = 3'd1;
    localparam logic [2:0] aluAnd = 3'd2;
    localparam logic [2:0] aluOr  = 3'd3;
    localparam logic [2:0] aluSlt = 3'd4;

    // one instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [5:0]          opcode;
            logic [regAddrW-1:0] rs;
            logic [regAddrW-1:0] rt;
            logic [regAddrW-1:0] rd;
            logic [4:0]          shamt;
            logic [5:0]          funct;
        } rFmt;
        struct packed {
            logic [5:0]          opcode;
            logic [regAddrW-1:0] rs;
            logic [regAddrW-1:0] rt;
            logic [15:0]         imm;
        } iFmt;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target;
        } jFmt;
    } instrWord;

endpackage

// File: fetch/fetchStage.sv
//######################################
// instruction fetch stage
//######################################
`timescale 1ns/1ps

module fetchStage import mipsPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 imemWrEn,
    input  logic [imemAddrW-1:0] imemWrAddr,
    input  instrWord             imemWrData,
    input  logic                 stall,
    input  logic                 redirect,
    input  logic [dataW-1:0]     redirectTarget,
    output instrWord             ifInstr,
    output logic [dataW-1:0]     ifPcNext,
    output logic                 ifValid
);

    instrWord         imem [imemDepth];
    instrWord         fetchWord;
    logic [dataW-1:0] pc;
    logic [dataW-1:0] pcPlus4;
    logic             halted;

    // program load port
    always_ff @(posedge clk) begin
        if (imemWrEn)
            imem[imemWrAddr] <= imemWrData;
    end

    assign fetchWord = imem[pc[imemAddrW+1:2]];
    assign pcPlus4   = pc + dataW'(4);

    // PC stops on a halt until a redirect squashes it
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc      <= '0;
            ifValid <= 1'b0;
            halted  <= 1'b0;
        end else if (redirect) begin
            pc      <= redirectTarget;
            ifValid <= 1'b0;
            halted  <= 1'b0;
        end else if (!stall) begin
            ifValid <= !halted;
            if (!halted) begin
                if (fetchWord.jFmt.opcode == opFin)
                    halted <= 1'b1;
                else
                    pc <= pcPlus4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ifInstr  <= fetchWord;
            ifPcNext <= pcPlus4;
        end
    end

endmodule

// File: decode/decodeStage.sv
//######################################
// decode stage and register file
//######################################
`timescale 1ns/1ps

module decodeStage import mipsPkg::*; (
    input  logic                clk,
    input  logic                rstN,
    input  instrWord            ifInstr,
    input  logic [dataW-1:0]    ifPcNext,
    input  logic                ifValid,
    input  logic                redirect,
    input  logic                wbValid,
    input  logic [regAddrW-1:0] wbReg,
    input  logic [dataW-1:0]    wbData,
    output logic                stall,
    output logic                exValid,
    output logic [2:0]          exAluOp,
    output logic                exUseImm,
    output logic                exMemRd,
    output logic                exMemWr,
    output logic                exRegWr,
    output logic                exBeq,
    output logic                exJump,
    output logic                exFin,
    output logic [regAddrW-1:0] exRs,
    output logic [regAddrW-1:0] exRt,
    output logic [regAddrW-1:0] exDest,
    output logic [dataW-1:0]    exRsVal,
    output logic [dataW-1:0]    exRtVal,
    output logic [dataW-1:0]    exImm,
    output logic [dataW-1:0]    exPcNext,
    output logic [dataW-1:0]    exJumpTarget
);

    logic [dataW-1:0]    regFile [2**regAddrW];
    logic [regAddrW-1:0] rs;
    logic [regAddrW-1:0] rt;
    logic [regAddrW-1:0] dest;
    logic [dataW-1:0]    rsVal;
    logic [dataW-1:0]    rtVal;
    logic [2:0]          aluOp;
    logic                useImm;
    logic                memRd;
    logic                memWr;
    logic                regWr;
    logic                isBeq;
    logic                isJump;
    logic                isFin;
    logic                bubble;

    assign rs = ifInstr.rFmt.rs;
    assign rt = ifInstr.rFmt.rt;

    always_comb begin
        aluOp  = aluAdd;
        useImm = 1'b0;
        memRd  = 1'b0;
        memWr  = 1'b0;
        regWr  = 1'b0;
        isBeq  = 1'b0;
        isJump = 1'b0;
        isFin  = 1'b0;
        dest   = ifInstr.iFmt.rt;
        case (ifInstr.rFmt.opcode)
            opRType: begin
                dest  = ifInstr.rFmt.rd;
                regWr = 1'b1;
                case (ifInstr.rFmt.funct)
                    fnAddu:  aluOp = aluAdd;
                    fnSubu:  aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnSlt:   aluOp = aluSlt;
                    // unknown funct retires as a nop
                    default: regWr = 1'b0;
                endcase
            end
            opAddiu: begin
                useImm = 1'b1;
                regWr  = 1'b1;
            end
            opLw: begin
                useImm = 1'b1;
                memRd  = 1'b1;
                regWr  = 1'b1;
            end
            opSw: begin
                useImm = 1'b1;
                memWr  = 1'b1;
            end
            opBeq:   isBeq  = 1'b1;
            opJ:     isJump = 1'b1;
            opFin:   isFin  = 1'b1;
            default: ;
        endcase
    end

    // register 0 reads zero, writeback value passes straight through
    assign rsVal = (rs == '0) ? '0 : (wbValid && wbReg == rs) ? wbData : regFile[rs];
    assign rtVal = (rt == '0) ? '0 : (wbValid && wbReg == rt) ? wbData : regFile[rt];

    always_ff @(posedge clk) begin
        if (wbValid)
            regFile[wbReg] <= wbData;
    end

    // load in execute feeding the instruction here
    assign stall  = ifValid && exValid && exMemRd && (exRt == rs || exRt == rt);
    assign bubble = !ifValid || stall || redirect;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exValid <= 1'b0;
            exMemRd <= 1'b0;
            exMemWr <= 1'b0;
            exRegWr <= 1'b0;
            exBeq   <= 1'b0;
            exJump  <= 1'b0;
            exFin   <= 1'b0;
        end else begin
            exValid <= !bubble;
            exMemRd <= memRd && !bubble;
            exMemWr <= memWr && !bubble;
            exRegWr <= regWr && !bubble;
            exBeq   <= isBeq && !bubble;
            exJump  <= isJump && !bubble;
            exFin   <= isFin && !bubble;
        end
    end

    always_ff @(posedge clk) begin
        exAluOp      <= aluOp;
        exUseImm     <= useImm;
        exRs         <= rs;
        exRt         <= rt;
        exDest       <= dest;
        exRsVal      <= rsVal;
        exRtVal      <= rtVal;
        exImm        <= {{(dataW-16){ifInstr.iFmt.imm[15]}}, ifInstr.iFmt.imm};
        exPcNext     <= ifPcNext;
        exJumpTarget <= {ifPcNext[dataW-1:28], ifInstr.jFmt.target, 2'b00};
    end

endmodule

// File: execute/executeStage.sv
//######################################
// execute stage, ALU and branches
//######################################
`timescale 1ns/1ps

module executeStage import mipsPkg::*; (
    input  logic                clk,
    input  logic                rstN,
    input  logic                exValid,
    input  logic [2:0]          exAluOp,
    input  logic                exUseImm,
    input  logic                exMemRd,
    input  logic                exMemWr,
    input  logic                exRegWr,
    input  logic                exBeq,
    input  logic                exJump,
    input  logic                exFin,
    input  logic [regAddrW-1:0] exRs,
    input  logic [regAddrW-1:0] exRt,
    input  logic [regAddrW-1:0] exDest,
    input  logic [dataW-1:0]    exRsVal,
    input  logic [dataW-1:0]    exRtVal,
    input  logic [dataW-1:0]    exImm,
    input  logic [dataW-1:0]    exPcNext,
    input  logic [dataW-1:0]    exJumpTarget,
    input  logic                wbValid,
    input  logic [regAddrW-1:0] wbReg,
    input  logic [dataW-1:0]    wbData,
    output logic                redirect,
    output logic [dataW-1:0]    redirectTarget,
    output logic                memValid,
    output logic                memRd,
    output logic                memWr,
    output logic                memRegWr,
    output logic                memFin,
    output logic [regAddrW-1:0] memDest,
    output logic [dataW-1:0]    memAluResult,
    output logic [dataW-1:0]    memStoreData
);

    logic             memHitRs;
    logic             memHitRt;
    logic             wbHitRs;
    logic             wbHitRt;
    logic [dataW-1:0] rsFwd;
    logic [dataW-1:0] rtFwd;
    logic [dataW-1:0] opB;
    logic [dataW-1:0] aluResult;
    logic [dataW-1:0] branchTarget;
    logic             branchTaken;

    // nearest older producer first, never register 0
    assign memHitRs = memValid && memRegWr && exRs != '0 && memDest == exRs;
    assign memHitRt = memValid && memRegWr && exRt != '0 && memDest == exRt;
    assign wbHitRs  = wbValid && exRs != '0 && wbReg == exRs;
    assign wbHitRt  = wbValid && exRt != '0 && wbReg == exRt;

    assign rsFwd = memHitRs ? memAluResult : wbHitRs ? wbData : exRsVal;
    assign rtFwd = memHitRt ? memAluResult : wbHitRt ? wbData : exRtVal;
    assign opB   = exUseImm ? exImm : rtFwd;

    always_comb begin
        case (exAluOp)
            aluAdd:  aluResult = rsFwd + opB;
            aluSub:  aluResult = rsFwd - opB;
            aluAnd:  aluResult = rsFwd & opB;
            aluOr:   aluResult = rsFwd | opB;
            aluSlt:  aluResult = {{(dataW-1){1'b0}}, $signed(rsFwd) < $signed(opB)};
            default: aluResult = '0;
        endcase
    end

    // resolved here, the two younger slots get squashed
    assign branchTaken    = exBeq && (rsFwd == rtFwd);
    assign branchTarget   = exPcNext + {exImm[dataW-3:0], 2'b00};
    assign redirect       = exValid && (exJump || branchTaken);
    assign redirectTarget = exJump ? exJumpTarget : branchTarget;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            memValid <= 1'b0;
            memRd    <= 1'b0;
            memWr    <= 1'b0;
            memRegWr <= 1'b0;
            memFin   <= 1'b0;
        end else begin
            memValid <= exValid;
            memRd    <= exMemRd;
            memWr    <= exMemWr;
            memRegWr <= exRegWr;
            memFin   <= exFin;
        end
    end

    always_ff @(posedge clk) begin
        memDest      <= exDest;
        memAluResult <= aluResult;
        memStoreData <= rtFwd;
    end

endmodule

// File: memory/memoryStage.sv
//######################################
// data memory and writeback
//######################################
`timescale 1ns/1ps

module memoryStage import mipsPkg::*; (
    input  logic                clk,
    input  logic                rstN,
    input  logic                memValid,
    input  logic                memRd,
    input  logic                memWr,
    input  logic                memRegWr,
    input  logic                memFin,
    input  logic [regAddrW-1:0] memDest,
    input  logic [dataW-1:0]    memAluResult,
    input  logic [dataW-1:0]    memStoreData,
    output logic                wbValid,
    output logic [regAddrW-1:0] wbReg,
    output logic [dataW-1:0]    wbData,
    output logic                fin
);

    localparam int dmemAddrW = $clog2(dmemDepth);

    logic [dataW-1:0]     dmem [dmemDepth];
    logic [dmemAddrW-1:0] dmemAddr;
    logic [dataW-1:0]     loadData;

    // word address from the byte address
    assign dmemAddr = memAluResult[dmemAddrW+1:2];
    assign loadData = dmem[dmemAddr];

    // store lands at the edge that closes this stage
    always_ff @(posedge clk) begin
        if (memValid && memWr)
            dmem[dmemAddr] <= memStoreData;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbValid <= 1'b0;
            fin     <= 1'b0;
        end else begin
            wbValid <= memValid && memRegWr && memDest != '0;
            // sticky until reset
            fin     <= fin || (memValid && memFin);
        end
    end

    always_ff @(posedge clk) begin
        wbReg  <= memDest;
        wbData <= memRd ? loadData : memAluResult;
    end

endmodule

// File: src/mipsPipeline.sv
//######################################
// MIPS five-stage pipeline top
//######################################
`timescale 1ns/1ps

module mipsPipeline import mipsPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 imemWrEn,
    input  logic [imemAddrW-1:0] imemWrAddr,
    input  instrWord             imemWrData,
    output logic                 wbValid,
    output logic [regAddrW-1:0]  wbReg,
    output logic [dataW-1:0]     wbData,
    output logic                 fin
);

    // fetch to decode
    instrWord            ifInstr;
    logic [dataW-1:0]    ifPcNext;
    logic                ifValid;
    logic                stall;

    // decode to execute
    logic                exValid;
    logic [2:0]          exAluOp;
    logic                exUseImm;
    logic                exMemRd;
    logic                exMemWr;
    logic                exRegWr;
    logic                exBeq;
    logic                exJump;
    logic                exFin;
    logic [regAddrW-1:0] exRs;
    logic [regAddrW-1:0] exRt;
    logic [regAddrW-1:0] exDest;
    logic [dataW-1:0]    exRsVal;
    logic [dataW-1:0]    exRtVal;
    logic [dataW-1:0]    exImm;
    logic [dataW-1:0]    exPcNext;
    logic [dataW-1:0]    exJumpTarget;

    // execute outputs
    logic                redirect;
    logic [dataW-1:0]    redirectTarget;
    logic                memValid;
    logic                memRd;
    logic                memWr;
    logic                memRegWr;
    logic                memFin;
    logic [regAddrW-1:0] memDest;
    logic [dataW-1:0]    memAluResult;
    logic [dataW-1:0]    memStoreData;

    fetchStage i_fetchStage (.*);

    decodeStage i_decodeStage (.*);

    executeStage i_executeStage (.*);

    memoryStage i_memoryStage (.*);

endmodule

// File: verification/mipsPipelineChecker.sv
//######################################
// pipeline output assertions
//######################################
`timescale 1ns/1ps

module mipsPipelineChecker import mipsPkg::*; (
    input logic                clk,
    input logic                rstN,
    input logic                wbValid,
    input logic [regAddrW-1:0] wbReg,
    input logic                fin
);

    // register 0 never retires
    wbRegNonZero: assert property (@(posedge clk) disable iff (!rstN)
        wbValid |-> wbReg != '0)
        else $error("writeback to register 0");

    finSticky: assert property (@(posedge clk) disable iff (!rstN)
        fin |=> fin)
        else $error("fin fell while out of reset");

    // outputs cleared by reset
    resetClears: assert property (@(posedge clk)
        !rstN |=> (!wbValid && !fin))
        else $error("wbValid or fin high after reset");

    wbValidKnown: assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown(wbValid))
        else $error("wbValid unknown");

endmodule

// File: verification/mipsPipelineTb.sv
//######################################
// MIPS pipeline testbench
//######################################
`timescale 1ns/1ps

module mipsPipelineTb import mipsPkg::*; ();

    localparam int resetCycles = 8;
    localparam int finTimeout  = 2000;
    localparam int holdCycles  = 10;

    logic                 clk = 1'b0;
    logic                 rstN;
    logic                 imemWrEn;
    logic [imemAddrW-1:0] imemWrAddr;
    instrWord             imemWrData;
    logic                 wbValid;
    logic [regAddrW-1:0]  wbReg;
    logic [dataW-1:0]     wbData;
    logic                 fin;

    // program image and expected writebacks
    logic [imemAddrW-1:0] progAddr [$];
    instrWord             progWord [$];
    logic [regAddrW-1:0]  expReg [$];
    logic [dataW-1:0]     expData [$];
    int                   expCount;

    int wbSeen;
    int wbErrors;
    int countErrors;
    int finErrors;
    int timeoutErrors;
    int fileErrors;

    mipsPipeline i_mipsPipeline (.*);

    bind mipsPipeline mipsPipelineChecker i_mipsPipelineChecker (
        .clk(clk),
        .rstN(rstN),
        .wbValid(wbValid),
        .wbReg(wbReg),
        .fin(fin)
    );

    always #20 clk = ~clk;

    task automatic matchWriteback(input logic [regAddrW-1:0] gotReg,
                                  input logic [dataW-1:0] gotData);
        if (wbSeen >= expReg.size()) begin
            $display("ERROR at %0t: extra writeback r%0d = %h", $time, gotReg, gotData);
            wbErrors++;
        end else if (gotReg !== expReg[wbSeen] || gotData !== expData[wbSeen]) begin
            $display("ERROR at %0t: writeback %0d is r%0d = %h, expected r%0d = %h",
                     $time, wbSeen, gotReg, gotData, expReg[wbSeen], expData[wbSeen]);
            wbErrors++;
        end
        wbSeen++;
    endtask

    task automatic expectFinHigh(input logic got);
        if (got !== 1'b1) begin
            $display("ERROR at %0t: fin is %b after rising, expected 1", $time, got);
            finErrors++;
        end
    endtask

    task automatic verifyWritebackCount(input int got, input int want);
        if (got != want) begin
            $display("ERROR at %0t: %0d writebacks seen, expected %0d", $time, got, want);
            countErrors++;
        end
    endtask

    // skips '#' lines and unknown tags
    task automatic readProgramFile();
        int               fd;
        int               code;
        int               r;
        byte              tag;
        logic [31:0]      a;
        logic [31:0]      v;
        logic [8*120-1:0] rest;
        fd = $fopen("verification/programGolden.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/programGolden.txt");
            fileErrors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %c", tag);
                if (code == 1) begin
                    case (tag)
                        "P": begin
                            code = $fscanf(fd, "%h %h", a, v);
                            progAddr.push_back(a[imemAddrW-1:0]);
                            progWord.push_back(v);
                        end
                        "W": begin
                            code = $fscanf(fd, "%d %h", r, v);
                            expReg.push_back(r[regAddrW-1:0]);
                            expData.push_back(v);
                        end
                        "F": code = $fscanf(fd, "%d", expCount);
                        default: code = $fgets(rest, fd);
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    // one check per retired write in program order
    always @(negedge clk) begin
        if (rstN && wbValid === 1'b1)
            matchWriteback(wbReg, wbData);
    end

    initial begin : mainFlow
        int cycles;
        rstN       <= 1'b0;
        imemWrEn   <= 1'b0;
        imemWrAddr <= '0;
        imemWrData <= '0;
        readProgramFile();
        if (fileErrors == 0) begin
            // program goes in while reset is low
            for (int i = 0; i < progAddr.size(); i++) begin
                @(posedge clk);
                imemWrEn   <= 1'b1;
                imemWrAddr <= progAddr[i];
                imemWrData <= progWord[i];
            end
            @(posedge clk);
            imemWrEn <= 1'b0;
            repeat (resetCycles) @(posedge clk);
            rstN <= 1'b1;
            cycles = 0;
            while (fin !== 1'b1 && cycles < finTimeout) begin
                @(negedge clk);
                cycles++;
            end
            if (fin !== 1'b1) begin
                $display("fin did not rise within %0d cycles", finTimeout);
                timeoutErrors++;
            end else begin
                // halt is sticky
                repeat (holdCycles) begin
                    @(negedge clk);
                    expectFinHigh(fin);
                end
            end
            // away from the negedge writeback counter
            @(posedge clk);
            verifyWritebackCount(wbSeen, expCount);
        end
        $display("errors: writeback %0d, count %0d, fin %0d, timeout %0d, file %0d",
                 wbErrors, countErrors, finErrors, timeoutErrors, fileErrors);
        if (wbErrors + countErrors + finErrors + timeoutErrors + fileErrors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: verification/programGolden.txt
# P <word address hex> <instruction hex>
# W <register dec> <value hex>, in retire order; F <number of writebacks>
P 00 24010005
P 01 2402fffd
P 02 00221821
P 03 00612023
P 04 00812824
P 05 00a33025
P 06 0041382a
P 07 0022402a
P 08 ac060010
P 09 8c090010
P 0a 01265021
P 0b 11410005
P 0c 10a10002
P 0d 240b0001
P 0e 240c0002
P 0f 254d0010
P 10 08000013
P 11 240e0055
P 12 240f0066
P 13 01a78025
P 14 00220021
P 15 fc000000
W 1 00000005
W 2 fffffffd
W 3 00000002
W 4 fffffffd
W 5 00000005
W 6 00000007
W 7 00000001
W 8 00000000
W 9 00000007
W 10 0000000e
W 13 0000001e
W 16 0000001f
F 12

// File: mipsPipeline.f
common/mipsPkg.sv
fetch/fetchStage.sv
decode/decodeStage.sv
execute/executeStage.sv
memory/memoryStage.sv
src/mipsPipeline.sv
verification/mipsPipelineChecker.sv
verification/mipsPipelineTb.sv

// File: runSim.sh
#!/bin/sh
# build and run the MIPS pipeline testbench with Verilator
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module mipsPipelineTb \
    -f mipsPipeline.f -o mipsPipelineSim \
    && ./obj_dir/mipsPipelineSim > sim.log 2>&1 \
    || echo "RESULT: FAIL" >> sim.log
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0
